// ==== include/soc_defines.svh ====
// simulation sized constants: one UART bit lasts 8 clocks, so raise it for a real baud rate
`ifndef SOC_DEFINES_SVH
`define SOC_DEFINES_SVH

// word address width of the data memory
`define SOC_ADDR_W 10

// memory depth in 32-bit words, must match SOC_ADDR_W
`define SOC_MEM_WORDS 1024

// clocks per UART bit
// 8 keeps simulation short, board needs CLK / baud
`define SOC_CLKS_PER_BIT 8

// cycles a button must hold still before the output follows
`define SOC_DB_CYCLES 16

// words sent per dump, always starting at address 0
// must stay below SOC_MEM_WORDS
`define SOC_DUMP_WORDS 8

`endif

// ==== rtl/soc_pkg.sv ====
// shared types only; state literals carry a block prefix since both machines have an idle
`include "soc_defines.svh"

package soc_pkg;

	// store port standing in for the core's store path
	// a cycle with any be bit set is a write
	typedef struct packed {
		logic [3:0]             be;
		logic [`SOC_ADDR_W-1:0] addr;
		logic [31:0]            data;
	} mem_wr_t;

	// serializer states, one per part of an 8N1 frame
	typedef enum logic [1:0] {
		UART_IDLE,
		UART_START,
		UART_DATA,
		UART_STOP
	} uart_state_e;

	// dump walker states
	typedef enum logic [2:0] {
		DUMP_IDLE,
		DUMP_READ,
		DUMP_LOAD,
		DUMP_SEND,
		DUMP_NEXT
	} dump_state_e;

endpackage

// ==== rtl/btn_debounce.sv ====
// four buttons only; output delay is roughly SOC_DB_CYCLES plus two sync cycles
`timescale 1ns/100ps
`include "soc_defines.svh"

module btn_debounce (
	input  logic       CLK,
	input  logic       arst_n,
	input  logic [3:0] btn,
	output logic [3:0] db_btn
);

	localparam int CNT_W = $clog2(`SOC_DB_CYCLES + 1);

	// two flop synchronizer, raw pins are async to CLK
	logic [3:0] sync_a;
	logic [3:0] sync_b;
	// one stability counter per button
	logic [CNT_W-1:0] cnt [4];

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			sync_a <= '0;
			sync_b <= '0;
		end else begin
			sync_a <= btn;
			sync_b <= sync_a;
		end
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			db_btn <= '0;
			for (int i = 0; i < 4; i++)
				cnt[i] <= '0;
		end else begin
			for (int i = 0; i < 4; i++) begin
				// matches output, nothing to filter
				if (sync_b[i] == db_btn[i]) begin
					cnt[i] <= '0;
				// held long enough, take it
				end else if (cnt[i] == CNT_W'(`SOC_DB_CYCLES)) begin
					db_btn[i] <= sync_b[i];
					cnt[i]    <= '0;
				end else begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

endmodule

// ==== rtl/data_mem.sv ====
// contents are not reset and power up unknown; a same-address read and write returns old data
`timescale 1ns/100ps
`include "soc_defines.svh"

module data_mem (
	input  logic                   CLK,
	input  soc_pkg::mem_wr_t       store,
	input  logic [`SOC_ADDR_W-1:0] rd_addr,
	output logic [31:0]            rd_data
);

	// 1024 x 32 word array
	logic [31:0] mem [`SOC_MEM_WORDS];

	// store port, one enable per byte lane
	always_ff @(posedge CLK) begin
		for (int b = 0; b < 4; b++) begin
			if (store.be[b])
				mem[store.addr][8*b +: 8] <= store.data[8*b +: 8];
		end
	end

	// dump port
	// registered, data one cycle after the address
	// nonblocking read so a colliding write shows next time
	always_ff @(posedge CLK) begin
		rd_data <= mem[rd_addr];
	end

endmodule

// ==== rtl/uart_tx.sv ====
// 8N1 transmit only, no parity; tx_load is taken only while tx_busy is low
`timescale 1ns/100ps
`include "soc_defines.svh"

module uart_tx (
	input  logic       CLK,
	input  logic       arst_n,
	input  logic [7:0] tx_byte,
	input  logic       tx_load,
	output logic       tx,
	output logic       tx_busy
);

	localparam int CNT_W = $clog2(`SOC_CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] BIT_END = CNT_W'(`SOC_CLKS_PER_BIT - 1);

	soc_pkg::uart_state_e state;
	// clocks into current bit
	logic [CNT_W-1:0] cnt;
	// data bit being sent
	logic [2:0] bit_idx;
	// remaining data bits, lsb goes out next
	logic [7:0] shreg;

	// busy for the whole frame including the stop bit
	assign tx_busy = (state != soc_pkg::UART_IDLE);

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state   <= soc_pkg::UART_IDLE;
			cnt     <= '0;
			bit_idx <= '0;
			shreg   <= '0;
			tx      <= 1'b1;
		end else begin
			unique case (state)
				soc_pkg::UART_IDLE: begin
					tx <= 1'b1;
					if (tx_load) begin
						// start bit goes out next cycle
						shreg <= tx_byte;
						cnt   <= '0;
						tx    <= 1'b0;
						state <= soc_pkg::UART_START;
					end
				end
				soc_pkg::UART_START: begin
					if (cnt == BIT_END) begin
						cnt     <= '0;
						bit_idx <= '0;
						tx      <= shreg[0];
						shreg   <= shreg >> 1;
						state   <= soc_pkg::UART_DATA;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				soc_pkg::UART_DATA: begin
					if (cnt == BIT_END) begin
						cnt <= '0;
						if (bit_idx == 3'd7) begin
							// stop bit
							tx    <= 1'b1;
							state <= soc_pkg::UART_STOP;
						end else begin
							tx      <= shreg[0];
							shreg   <= shreg >> 1;
							bit_idx <= bit_idx + 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				soc_pkg::UART_STOP: begin
					// line already high, just time it out
					if (cnt == BIT_END)
						state <= soc_pkg::UART_IDLE;
					else
						cnt <= cnt + 1'b1;
				end
				default: state <= soc_pkg::UART_IDLE;
			endcase
		end
	end

endmodule

// ==== rtl/uart_mem_dump.sv ====
// dumps words 0 to SOC_DUMP_WORDS-1 only, lsb first; a start pulse while busy is dropped
`timescale 1ns/100ps
`include "soc_defines.svh"

module uart_mem_dump (
	input  logic                   CLK,
	input  logic                   arst_n,
	input  logic                   dump_start,
	input  logic [31:0]            rd_data,
	output logic [`SOC_ADDR_W-1:0] rd_addr,
	output logic                   dump_busy,
	output logic                   tx
);

	localparam logic [`SOC_ADDR_W-1:0] LAST_ADDR = `SOC_ADDR_W'(`SOC_DUMP_WORDS - 1);

	soc_pkg::dump_state_e state;
	// word address being dumped
	logic [`SOC_ADDR_W-1:0] addr;
	// bytes of the current word already handed over
	logic [1:0] byte_idx;
	// captured word, shifted down a byte per load
	logic [31:0] word;
	logic [7:0]  tx_byte;
	logic        tx_load;
	logic        tx_busy;

	assign rd_addr   = addr;
	assign dump_busy = (state != soc_pkg::DUMP_IDLE);
	assign tx_byte   = word[7:0];
	// hand a byte over as soon as the serializer is free
	assign tx_load   = (state == soc_pkg::DUMP_SEND) && !tx_busy;

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state    <= soc_pkg::DUMP_IDLE;
			addr     <= '0;
			byte_idx <= '0;
		end else begin
			unique case (state)
				soc_pkg::DUMP_IDLE: begin
					if (dump_start) begin
						addr  <= '0;
						state <= soc_pkg::DUMP_READ;
					end
				end
				// address on the port, data valid next cycle
				soc_pkg::DUMP_READ: state <= soc_pkg::DUMP_LOAD;
				soc_pkg::DUMP_LOAD: begin
					byte_idx <= '0;
					state    <= soc_pkg::DUMP_SEND;
				end
				soc_pkg::DUMP_SEND: begin
					if (tx_load) begin
						byte_idx <= byte_idx + 1'b1;
						if (byte_idx == 2'd3)
							state <= soc_pkg::DUMP_NEXT;
					end
				end
				soc_pkg::DUMP_NEXT: begin
					// last word waits out its final frame before going idle
					if (addr != LAST_ADDR) begin
						addr  <= addr + 1'b1;
						state <= soc_pkg::DUMP_READ;
					end else if (!tx_busy) begin
						state <= soc_pkg::DUMP_IDLE;
					end
				end
				default: state <= soc_pkg::DUMP_IDLE;
			endcase
		end
	end

	// word register
	always_ff @(posedge CLK) begin
		if (state == soc_pkg::DUMP_LOAD)
			word <= rd_data;
		else if (tx_load)
			word <= {8'h00, word[31:8]};
	end

	uart_tx UARTTX (
		.CLK     (CLK),
		.arst_n  (arst_n),
		.tx_byte (tx_byte),
		.tx_load (tx_load),
		.tx      (tx),
		.tx_busy (tx_busy)
	);

endmodule

// ==== rtl/soc_top.sv ====
// core left out, its store port and interrupt are pins; runs on CLK directly, no clock IP
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_top (
	input  logic             CLK,
	input  logic             arst_n,
	// board pins
	input  logic [3:0]       btn,
	input  logic [2:0]       sw,
	// core store path
	input  soc_pkg::mem_wr_t store,
	input  logic             dump_start,
	output logic [3:0]       led,
	output logic             int_sig,
	output logic             tx,
	output logic             dump_busy
);

	logic [3:0]             db_btn;
	// dump read port
	logic [`SOC_ADDR_W-1:0] rd_addr;
	logic [31:0]            rd_data;

	// interrupt request, any settled button or any switch
	assign int_sig = (|db_btn) | (|sw);
	assign led     = db_btn;

	btn_debounce DEBOUNCE (
		.CLK    (CLK),
		.arst_n (arst_n),
		.btn    (btn),
		.db_btn (db_btn)
	);

	data_mem DATAMEM (
		.CLK     (CLK),
		.store   (store),
		.rd_addr (rd_addr),
		.rd_data (rd_data)
	);

	uart_mem_dump UARTDUMP (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.dump_start (dump_start),
		.rd_data    (rd_data),
		.rd_addr    (rd_addr),
		.dump_busy  (dump_busy),
		.tx         (tx)
	);

endmodule

// ==== verification/soc_top_assert.sv ====
// bound into uart_mem_dump; the address check assumes the dump window starts at word 0
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_top_assert (
	input logic                   CLK,
	input logic                   arst_n,
	input logic                   dump_start,
	input logic                   dump_busy,
	input logic [`SOC_ADDR_W-1:0] rd_addr,
	input logic                   tx,
	input logic                   tx_load,
	input logic                   tx_busy
);

	// idle serializer holds the line at mark
	idle_line_high: assert property (@(posedge CLK) disable iff (!arst_n)
		!tx_busy |-> tx)
		else $error("tx low while the serializer is idle");

	// handed byte opens a frame on the next clock
	load_starts_frame: assert property (@(posedge CLK) disable iff (!arst_n)
		tx_load |=> (tx_busy && !tx))
		else $error("tx_load did not start a frame on the next clock");

	busy_needs_start: assert property (@(posedge CLK) disable iff (!arst_n)
		$rose(dump_busy) |-> $past(dump_start))
		else $error("dump_busy rose without dump_start");

	// walker never leaves the window
	addr_in_window: assert property (@(posedge CLK) disable iff (!arst_n)
		dump_busy |-> (rd_addr < `SOC_DUMP_WORDS))
		else $error("rd_addr outside the dump window while busy");

endmodule

bind uart_mem_dump soc_top_assert ASSERTS (
	.CLK        (CLK),
	.arst_n     (arst_n),
	.dump_start (dump_start),
	.dump_busy  (dump_busy),
	.rd_addr    (rd_addr),
	.tx         (tx),
	.tx_load    (tx_load),
	.tx_busy    (tx_busy)
);

// ==== verification/soc_top_tb.sv ====
// dump window only is compared; no stores are driven during a dump, so the memory model stays valid
`timescale 1ns/100ps
`include "soc_defines.svh"

module soc_top_tb;

	localparam int DRV        = 10;
	localparam int BIT_CLKS   = `SOC_CLKS_PER_BIT;
	localparam int DUMP_BYTES = 4 * `SOC_DUMP_WORDS;
	localparam int DB_HOLD    = 2 * `SOC_DB_CYCLES + 2;
	// longest gap between frames while the dumper is busy
	localparam int GAP_LIMIT  = 12 * BIT_CLKS;

	logic             CLK;
	logic             arst_n;
	logic [3:0]       btn;
	logic [2:0]       sw;
	soc_pkg::mem_wr_t store;
	logic             dump_start;
	logic [3:0]       led;
	logic             int_sig;
	logic             tx;
	logic             dump_busy;

	// reference copy of the data memory
	logic [31:0] model [`SOC_MEM_WORDS];
	// bytes seen on tx during the last dump
	logic [7:0]  rx_q [$];
	int errors, err_mark, checks, tests, failed;

	soc_top UUT (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.btn        (btn),
		.sw         (sw),
		.store      (store),
		.dump_start (dump_start),
		.led        (led),
		.int_sig    (int_sig),
		.tx         (tx),
		.dump_busy  (dump_busy)
	);

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	// inputs change a little after the rising edge
	task automatic step_clock();
		@(posedge CLK);
		#DRV;
	endtask

	task automatic start_test();
		err_mark = errors;
	endtask

	task automatic finish_test(input string name);
		tests++;
		if (errors == err_mark) begin
			$display("test %s: ok", name);
		end else begin
			failed++;
			$display("test %s: %0d errors", name, errors - err_mark);
		end
	endtask

	task automatic report_problem(input string text);
		errors++;
		$display("[ERROR] %s", text);
	endtask

	task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	task automatic check_nibble(input string name, input logic [3:0] exp, input logic [3:0] act);
		checks++;
		if (act !== exp) begin
			errors++;
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
		end
	endtask

	// one store cycle mirrored into the model lane by lane
	task automatic write_store(input logic [3:0] be, input logic [`SOC_ADDR_W-1:0] addr,
		input logic [31:0] data);
		store.be   = be;
		store.addr = addr;
		store.data = data;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				model[addr][8*b +: 8] = data[8*b +: 8];
		end
		step_clock();
		store.be = 4'h0;
	endtask

	task automatic start_dump(output bit ok);
		int t;
		dump_start = 1'b1;
		step_clock();
		dump_start = 1'b0;
		ok = 1'b0;
		t = 0;
		while (!ok && t < 4) begin
			@(negedge CLK);
			ok = (dump_busy === 1'b1);
			t++;
		end
		if (!ok)
			report_problem("dump_busy did not rise after dump_start");
	endtask

	// entered at the falling edge where the start bit was first seen
	// samples each bit near its middle
	task automatic receive_frame(output logic [7:0] data);
		repeat (BIT_CLKS / 2) @(negedge CLK);
		if (tx !== 1'b0)
			report_problem("start bit did not hold low");
		for (int i = 0; i < 8; i++) begin
			repeat (BIT_CLKS) @(negedge CLK);
			data[i] = tx;
		end
		repeat (BIT_CLKS) @(negedge CLK);
		if (tx !== 1'b1)
			report_problem("stop bit was low");
	endtask

	// gathers frames until dump_busy falls
	task automatic collect_dump();
		logic [7:0] b;
		int idle_t;
		bit done;
		rx_q.delete();
		idle_t = 0;
		done = 1'b0;
		while (!done) begin
			@(negedge CLK);
			if (tx === 1'b0) begin
				receive_frame(b);
				rx_q.push_back(b);
				idle_t = 0;
				// stop listening to a runaway dump
				if (rx_q.size() > DUMP_BYTES + 4) begin
					report_problem("dump kept sending past the window");
					done = 1'b1;
				end
			end else if (dump_busy !== 1'b1) begin
				done = 1'b1;
			end else if (idle_t > GAP_LIMIT) begin
				report_problem("no frame started while dump_busy was high");
				done = 1'b1;
			end else begin
				idle_t++;
			end
		end
	endtask

	// rebuild words lsb first and compare with the model
	task automatic compare_dump(input string name);
		logic [31:0] w;
		if (rx_q.size() < DUMP_BYTES) begin
			report_problem($sformatf("%s received only %0d bytes", name, rx_q.size()));
		end else begin
			for (int i = 0; i < `SOC_DUMP_WORDS; i++) begin
				w = {rx_q[4*i+3], rx_q[4*i+2], rx_q[4*i+1], rx_q[4*i]};
				check_word($sformatf("%s word %0d", name, i), model[i], w);
			end
		end
	endtask

	task automatic wait_led(input logic [3:0] exp, input int limit);
		int t;
		t = 0;
		while (led !== exp && t < limit) begin
			step_clock();
			t++;
		end
		if (led !== exp)
			report_problem($sformatf("led did not settle to %h within %0d cycles", exp, limit));
	endtask

	initial begin
		bit ok;
		int i;
		int k;
		int width;
		logic [3:0] cur;
		logic [3:0] nv;
		logic [3:0] mask;
		logic [2:0] swv;
		void'($urandom(67036));
		errors = 0;
		err_mark = 0;
		checks = 0;
		tests = 0;
		failed = 0;
		arst_n = 1'b0;
		btn = 4'h0;
		sw = 3'h0;
		store = '0;
		dump_start = 1'b0;
		repeat (8) @(posedge CLK);
		#DRV arst_n = 1'b1;

		start_test();
		step_clock();
		check_nibble("reset_state led", 4'h0, led);
		// tx, dump_busy, int_sig
		check_nibble("reset_state lines", 4'b0100, {1'b0, tx, dump_busy, int_sig});
		finish_test("reset_state");

		// every window word written whole before partial overwrites
		start_test();
		for (i = 0; i < `SOC_DUMP_WORDS; i++)
			write_store(4'hF, `SOC_ADDR_W'(i), $urandom());
		for (k = 0; k < 24; k++)
			write_store(4'($urandom_range(15, 1)),
				`SOC_ADDR_W'($urandom_range(`SOC_DUMP_WORDS - 1, 0)), $urandom());
		// a few stores outside the window must not show up
		for (k = 0; k < 4; k++)
			write_store(4'hF, `SOC_ADDR_W'($urandom_range(`SOC_MEM_WORDS - 1,
				`SOC_DUMP_WORDS)), $urandom());
		start_dump(ok);
		if (ok) begin
			collect_dump();
			compare_dump("store_dump");
		end
		finish_test("store_dump");

		start_test();
		step_clock();
		start_dump(ok);
		if (ok) begin
			// extra start while busy must be dropped
			step_clock();
			dump_start = 1'b1;
			step_clock();
			dump_start = 1'b0;
			collect_dump();
			check_byte("dump_count bytes", 8'(DUMP_BYTES), 8'(rx_q.size()));
			compare_dump("dump_count");
			// line must stay quiet after the dump ends
			for (k = 0; k < 2 * 10 * BIT_CLKS; k++) begin
				@(negedge CLK);
				if (tx !== 1'b1 || dump_busy !== 1'b0) begin
					report_problem("activity on tx or dump_busy after the dump ended");
					k = 2 * 10 * BIT_CLKS;
				end
			end
		end
		finish_test("dump_count");

		start_test();
		step_clock();
		cur = 4'h0;
		for (k = 0; k < 4; k++) begin
			// short glitches around the settled value
			for (i = 0; i < 6; i++) begin
				mask = 4'($urandom_range(15, 1));
				width = $urandom_range(`SOC_DB_CYCLES - 2, 1);
				btn = cur ^ mask;
				repeat (width) step_clock();
				btn = cur;
				repeat (4) step_clock();
				check_nibble("debounce glitch", cur, led);
			end
			nv = cur ^ 4'($urandom_range(15, 1));
			btn = nv;
			wait_led(nv, DB_HOLD);
			check_nibble("debounce hold", nv, led);
			cur = nv;
		end
		finish_test("debounce");

		start_test();
		for (k = 0; k < 8; k++) begin
			nv = 4'($urandom_range(15, 0));
			swv = 3'($urandom_range(7, 0));
			btn = nv;
			sw = swv;
			wait_led(nv, DB_HOLD);
			step_clock();
			check_nibble("irq led", nv, led);
			check_nibble("irq int_sig", {3'b000, (|nv) | (|swv)}, {3'b000, int_sig});
		end
		finish_test("irq");

		$display("tests %0d, failed tests %0d, checks %0d, errors %0d",
			tests, failed, checks, errors);
		if (errors == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule

// ==== soc_top.f ====
+incdir+include
rtl/soc_pkg.sv
rtl/btn_debounce.sv
rtl/data_mem.sv
rtl/uart_tx.sv
rtl/uart_mem_dump.sv
rtl/soc_top.sv
verification/soc_top_assert.sv
verification/soc_top_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = soc_top_tb
FILELIST  = soc_top.f
OBJ_DIR   = obj_dir
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# fails unless the pass line appears in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
